// File: include/ecc_map.svh
`ifndef ECC_MAP_SVH
`define ECC_MAP_SVH

// APB word addresses of the scratchpad

// Data window, DEPTH words of corrected data
localparam logic [7:0] data_base = 8'h00;
// Raw window, DEPTH whole codewords
localparam logic [7:0] raw_base = 8'h40;

// Bit 0 selects codec bypass
localparam logic [7:0] ctrl_addr = 8'h80;
// Saturating error counters, any write clears them
localparam logic [7:0] sbit_cnt_addr = 8'h81;
localparam logic [7:0] dbit_cnt_addr = 8'h82;
localparam logic [7:0] last_err_addr = 8'h83;

// Flag positions in a data window read word
localparam int rd_sbit_bit = 16;
localparam int rd_dbit_bit = 17;

`endif

// File: logic/ecc_pkg.sv
package ecc_pkg;

    // SEC-DED code geometry
    localparam int data_w = 10;
    localparam int parity_w = 5;
    localparam int code_w = data_w + parity_w;

    // APB data width and word address width
    localparam int bus_w = 32;
    localparam int addr_w = 8;

    typedef struct packed {
        logic [parity_w-1:0] parity;
        logic [data_w-1:0]   data;
    } ecc_fields_t;

    // A stored codeword, split on the normal path and whole in the raw window
    typedef union packed {
        ecc_fields_t         fields;
        logic [code_w-1:0]   raw;
    } ecc_word_u;

endpackage

// File: logic/ecc_codec.sv
`timescale 1ns/10ps

module ecc_codec
    import ecc_pkg::*;
(
    input  logic [data_w-1:0]   data_in,
    input  logic [parity_w-1:0] parity_in,
    input  logic                bypass,
    output logic [data_w-1:0]   data_out,
    output logic [parity_w-1:0] parity_out,
    output logic                sbit_err,
    output logic                dbit_err
);

    // Check matrix column of each data bit, bit j set when parity bit j covers it.
    // Every column has weight 3, so no data error looks like a parity bit error
    localparam logic [parity_w-1:0] h_col [data_w] = '{
        5'b10011,
        5'b10101,
        5'b10110,
        5'b00111,
        5'b11001,
        5'b11010,
        5'b01011,
        5'b11100,
        5'b01101,
        5'b01110
    };

    logic [parity_w-1:0] syndrome;
    logic [data_w-1:0]   flip;
    logic                single;

    // Parity is the XOR of the columns of all set data bits
    always_comb begin
        parity_out = '0;
        for (int i = 0; i < data_w; i++) begin
            parity_out = parity_out ^ (h_col[i] & {parity_w{data_in[i]}});
        end
    end

    assign syndrome = parity_in ^ parity_out;

    always_comb begin
        flip = '0;
        for (int i = 0; i < data_w; i++) begin
            if (syndrome == h_col[i]) begin
                flip[i] = 1'b1;
            end
        end
    end

    // A matching column is a data bit error, a lone syndrome bit is a parity bit error
    assign single = (|flip) || $onehot(syndrome);

    assign data_out = bypass ? data_in : data_in ^ flip;
    assign sbit_err = ~bypass & single;
    assign dbit_err = ~bypass & (syndrome != '0) & ~single;

endmodule

// File: logic/ecc_store.sv
`timescale 1ns/10ps

module ecc_store
    import ecc_pkg::*;
#(
    parameter int DEPTH = 16,
    localparam int aw = $clog2(DEPTH)
) (
    input  logic            pclk,
    input  logic            we,
    input  logic [aw-1:0]   waddr,
    input  ecc_word_u       wdata,
    input  logic [aw-1:0]   raddr,
    output ecc_word_u       rdata
);

    ecc_word_u mem [DEPTH];

    // One write port and a registered read that follows raddr by one clock
    always_ff @(posedge pclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

// File: logic/ecc_apb_port.sv
`timescale 1ns/10ps

`include "ecc_map.svh"

module ecc_apb_port
    import ecc_pkg::*;
#(
    parameter int DEPTH = 16,
    localparam int aw = $clog2(DEPTH)
) (
    input  logic                pclk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [addr_w-1:0]   paddr,
    input  logic [bus_w-1:0]    pwdata,
    output logic [bus_w-1:0]    prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                mem_we,
    output logic [aw-1:0]       mem_waddr,
    output ecc_word_u           mem_wdata,
    output logic [aw-1:0]       mem_raddr,
    input  ecc_word_u           mem_rdata,
    output logic [data_w-1:0]   codec_data,
    output logic [parity_w-1:0] codec_parity,
    output logic                bypass,
    input  logic [data_w-1:0]   codec_out,
    input  logic [parity_w-1:0] codec_parity_out,
    input  logic                sbit_err,
    input  logic                dbit_err
);

    localparam int cnt_w = 16;

    logic              setup;
    logic              access;
    logic              done;
    logic              in_data;
    logic              in_raw;
    logic              in_reg;
    logic              unmapped;
    logic              win_rd;
    logic              rd_fire;
    logic [aw-1:0]     idx;
    logic [cnt_w-1:0]  sbit_cnt;
    logic [cnt_w-1:0]  dbit_cnt;
    logic [aw-1:0]     last_err;
    logic [bus_w-1:0]  rd_word;

    assign setup  = psel & ~penable;
    assign access = psel & penable;
    assign done   = access & pready;

    assign in_data  = (paddr >= data_base) && (paddr < data_base + DEPTH);
    assign in_raw   = (paddr >= raw_base) && (paddr < raw_base + DEPTH);
    assign in_reg   = paddr inside {ctrl_addr, sbit_cnt_addr, dbit_cnt_addr, last_err_addr};
    assign unmapped = ~(in_data | in_raw | in_reg);

    // Window reads wait one access cycle for the store and rd_fire ends that wait
    assign win_rd  = ~pwrite & (in_data | in_raw);
    assign rd_fire = access & ~pready & win_rd;

    // Both windows are aligned to 64 words and the index is the low address bits
    assign idx = paddr[aw-1:0];

    // The read address is presented from the setup cycle on
    assign mem_raddr = idx;
    assign mem_waddr = idx;
    assign mem_we    = done & pwrite & (in_data | in_raw);

    always_comb begin
        if (in_raw) begin
            mem_wdata.raw = pwdata[code_w-1:0];
        end else begin
            mem_wdata.fields.parity = codec_parity_out;
            mem_wdata.fields.data = pwdata[data_w-1:0];
        end
    end

    // The codec encodes write data and checks stored words with the same logic
    assign codec_data   = (pwrite & in_data) ? pwdata[data_w-1:0] : mem_rdata.fields.data;
    assign codec_parity = mem_rdata.fields.parity;

    always_comb begin
        rd_word = '0;
        if (in_data) begin
            rd_word[data_w-1:0] = codec_out;
            rd_word[rd_sbit_bit] = sbit_err;
            rd_word[rd_dbit_bit] = dbit_err;
        end else if (in_raw) begin
            rd_word[code_w-1:0] = mem_rdata.raw;
        end else begin
            case (paddr)
                ctrl_addr:     rd_word[0] = bypass;
                sbit_cnt_addr: rd_word[cnt_w-1:0] = sbit_cnt;
                dbit_cnt_addr: rd_word[cnt_w-1:0] = dbit_cnt;
                last_err_addr: rd_word[aw-1:0] = last_err;
                default:       rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            pready <= 1'b0;
            pslverr <= 1'b0;
            bypass <= 1'b0;
            sbit_cnt <= '0;
            dbit_cnt <= '0;
            last_err <= '0;
        end else begin
            // Writes, register reads and unmapped accesses finish in the first access cycle
            pready <= (setup & ~win_rd) | rd_fire;
            pslverr <= (setup & ~win_rd & unmapped) | (rd_fire & in_data & dbit_err);

            if (done & pwrite) begin
                case (paddr)
                    ctrl_addr:     bypass <= pwdata[0];
                    sbit_cnt_addr: sbit_cnt <= '0;
                    dbit_cnt_addr: dbit_cnt <= '0;
                    default:       ;
                endcase
            end

            if (rd_fire && in_data) begin
                if (sbit_err && (sbit_cnt != '1)) begin
                    sbit_cnt <= sbit_cnt + 1'b1;
                end
                if (dbit_err && (dbit_cnt != '1)) begin
                    dbit_cnt <= dbit_cnt + 1'b1;
                end
                if (sbit_err || dbit_err) begin
                    last_err <= idx;
                end
            end
        end
    end

    always_ff @(posedge pclk) begin
        if ((setup & ~win_rd) | rd_fire) begin
            prdata <= pwrite ? '0 : rd_word;
        end
    end

endmodule

// File: logic/ecc_scratchpad.sv
`timescale 1ns/10ps

module ecc_scratchpad
    import ecc_pkg::*;
#(
    parameter int DEPTH = 16,
    localparam int aw = $clog2(DEPTH)
) (
    input  logic                pclk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [addr_w-1:0]   paddr,
    input  logic [bus_w-1:0]    pwdata,
    output logic [bus_w-1:0]    prdata,
    output logic                pready,
    output logic                pslverr
);

    logic                mem_we;
    logic [aw-1:0]       mem_waddr;
    ecc_word_u           mem_wdata;
    logic [aw-1:0]       mem_raddr;
    ecc_word_u           mem_rdata;
    logic [data_w-1:0]   codec_data;
    logic [parity_w-1:0] codec_parity;
    logic                bypass;
    logic [data_w-1:0]   codec_out;
    logic [parity_w-1:0] codec_parity_out;
    logic                sbit_err;
    logic                dbit_err;

    ecc_apb_port #(
        .DEPTH(DEPTH)
    ) port0 (
        .pclk(pclk),
        .rst(rst),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .mem_we(mem_we),
        .mem_waddr(mem_waddr),
        .mem_wdata(mem_wdata),
        .mem_raddr(mem_raddr),
        .mem_rdata(mem_rdata),
        .codec_data(codec_data),
        .codec_parity(codec_parity),
        .bypass(bypass),
        .codec_out(codec_out),
        .codec_parity_out(codec_parity_out),
        .sbit_err(sbit_err),
        .dbit_err(dbit_err)
    );

    ecc_store #(
        .DEPTH(DEPTH)
    ) store0 (
        .pclk(pclk),
        .we(mem_we),
        .waddr(mem_waddr),
        .wdata(mem_wdata),
        .raddr(mem_raddr),
        .rdata(mem_rdata)
    );

    ecc_codec codec0 (
        .data_in(codec_data),
        .parity_in(codec_parity),
        .bypass(bypass),
        .data_out(codec_out),
        .parity_out(codec_parity_out),
        .sbit_err(sbit_err),
        .dbit_err(dbit_err)
    );

endmodule

// File: testbench/ecc_scratchpad_assertions.sv
`timescale 1ns/10ps

module ecc_scratchpad_assertions (
    input logic pclk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr
);

    int fail_count = 0;

    // An error response is only valid together with pready
    assert property (@(posedge pclk) disable iff (rst) pslverr |-> pready)
        else begin
            $error("pslverr high without pready");
            fail_count++;
        end

    // The slave never completes in the setup cycle
    assert property (@(posedge pclk) disable iff (rst) (psel && !penable) |-> !pready)
        else begin
            $error("pready high in a setup cycle");
            fail_count++;
        end

    assert property (@(posedge pclk) disable iff (rst) (pready && !psel) |=> !(pready && !psel))
        else begin
            $error("pready held high while psel is low");
            fail_count++;
        end

    // Synchronous reset clears the response at the next edge
    assert property (@(posedge pclk) rst |=> (!pready && !pslverr))
        else begin
            $error("pready or pslverr high during reset");
            fail_count++;
        end

endmodule

bind ecc_apb_port ecc_scratchpad_assertions asrt0 (
    .pclk(pclk),
    .rst(rst),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .pslverr(pslverr)
);

// File: testbench/ecc_scratchpad_tb.sv
`timescale 1ns/10ps

`include "ecc_map.svh"

module ecc_scratchpad_tb
    import ecc_pkg::*;
();

    localparam int depth = 16;

    typedef struct packed {
        logic              is_write;
        logic [7:0]        addr;
        logic [bus_w-1:0]  wdata;
        logic [bus_w-1:0]  exp_rdata;
        logic              check_rdata;
        logic              exp_err;
    } txn_t;

    logic              pclk;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [addr_w-1:0] paddr;
    logic [bus_w-1:0]  pwdata;
    logic [bus_w-1:0]  prdata;
    logic              pready;
    logic              pslverr;

    txn_t              txns[$];
    logic [15:0]       lfsr_state = 16'd34;
    logic [data_w-1:0] words [depth];
    int                errors = 0;
    bit                table_built = 1'b0;

    ecc_scratchpad #(
        .DEPTH(depth)
    ) dut0 (
        .pclk(pclk),
        .rst(rst),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr)
    );

    initial begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;
    end

    // Galois LFSR for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? (s >> 1) ^ 16'hB400 : s >> 1;
    endfunction

    function automatic logic [data_w-1:0] take_bits(input int n);
        logic [data_w-1:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v[k] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Each parity bit covers six data bits, every data bit sits in exactly three of them
    function automatic logic [parity_w-1:0] model_parity(input logic [data_w-1:0] d);
        logic [parity_w-1:0] p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9];
        p[3] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9];
        p[4] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7];
        return p;
    endfunction

    function automatic logic [bus_w-1:0] codeword(input logic [data_w-1:0] d,
                                                  input logic [code_w-1:0] flips);
        ecc_word_u w;
        w.fields.parity = model_parity(d);
        w.fields.data = d;
        return {{(bus_w - code_w){1'b0}}, w.raw ^ flips};
    endfunction

    function automatic logic [bus_w-1:0] read_word(input logic [data_w-1:0] d,
                                                   input logic s, input logic db);
        logic [bus_w-1:0] w;
        w = '0;
        w[data_w-1:0] = d;
        w[rd_sbit_bit] = s;
        w[rd_dbit_bit] = db;
        return w;
    endfunction

    task automatic add_write(input logic [7:0] addr, input logic [bus_w-1:0] data,
                             input logic err);
        txns.push_back(txn_t'{1'b1, addr, data, 32'h0, 1'b0, err});
    endtask

    task automatic add_read(input logic [7:0] addr, input logic [bus_w-1:0] exp,
                            input logic err);
        txns.push_back(txn_t'{1'b0, addr, 32'h0, exp, 1'b1, err});
    endtask

    task automatic build_table();
        for (int i = 0; i < depth; i++) begin
            words[i] = take_bits(data_w);
        end
        add_read(ctrl_addr, 32'd0, 1'b0);
        add_read(sbit_cnt_addr, 32'd0, 1'b0);
        add_read(dbit_cnt_addr, 32'd0, 1'b0);
        add_read(last_err_addr, 32'd0, 1'b0);
        for (int i = 0; i < depth; i++) begin
            add_write(8'(data_base + i), {22'h0, words[i]}, 1'b0);
        end
        for (int i = 0; i < depth; i++) begin
            add_read(8'(data_base + i), read_word(words[i], 1'b0, 1'b0), 1'b0);
            add_read(8'(raw_base + i), codeword(words[i], 15'h0), 1'b0);
        end
        // Data bit 4 of word 3, then parity bit 2 of word 7
        add_write(8'(raw_base + 3), codeword(words[3], 15'h0010), 1'b0);
        add_read(8'(data_base + 3), read_word(words[3], 1'b1, 1'b0), 1'b0);
        add_read(sbit_cnt_addr, 32'd1, 1'b0);
        add_read(last_err_addr, 32'd3, 1'b0);
        add_write(8'(raw_base + 7), codeword(words[7], 15'h1000), 1'b0);
        add_read(8'(data_base + 7), read_word(words[7], 1'b1, 1'b0), 1'b0);
        add_read(sbit_cnt_addr, 32'd2, 1'b0);
        add_read(last_err_addr, 32'd7, 1'b0);
        // A double error is detected but the data is left as stored
        add_write(8'(raw_base + 10), codeword(words[10], 15'h0104), 1'b0);
        add_read(8'(data_base + 10), read_word(words[10] ^ 10'h104, 1'b0, 1'b1), 1'b1);
        add_read(dbit_cnt_addr, 32'd1, 1'b0);
        add_read(sbit_cnt_addr, 32'd2, 1'b0);
        add_read(last_err_addr, 32'd10, 1'b0);
        add_write(ctrl_addr, 32'd1, 1'b0);
        add_read(ctrl_addr, 32'd1, 1'b0);
        add_write(8'(raw_base + 5), codeword(words[5], 15'h0001), 1'b0);
        add_read(8'(data_base + 5), read_word(words[5] ^ 10'h001, 1'b0, 1'b0), 1'b0);
        add_read(8'(data_base + 10), read_word(words[10] ^ 10'h104, 1'b0, 1'b0), 1'b0);
        add_read(sbit_cnt_addr, 32'd2, 1'b0);
        add_read(dbit_cnt_addr, 32'd1, 1'b0);
        add_write(ctrl_addr, 32'd0, 1'b0);
        add_read(8'(data_base + 5), read_word(words[5], 1'b1, 1'b0), 1'b0);
        add_read(sbit_cnt_addr, 32'd3, 1'b0);
        add_read(last_err_addr, 32'd5, 1'b0);
        add_write(sbit_cnt_addr, 32'hffff, 1'b0);
        add_read(sbit_cnt_addr, 32'd0, 1'b0);
        add_write(dbit_cnt_addr, 32'hffff, 1'b0);
        add_read(dbit_cnt_addr, 32'd0, 1'b0);
        add_read(8'h20, 32'd0, 1'b1);
        add_read(8'(raw_base + depth), 32'd0, 1'b1);
        add_write(8'h90, 32'h1234, 1'b1);
    endtask

    task automatic apb_transfer(input txn_t t, output logic [bus_w-1:0] rdata,
                                output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = t.is_write;
        paddr = t.addr;
        pwdata = t.wdata;
        @(posedge pclk);
        #5;
        penable = 1'b1;
        while (pready !== 1'b1) begin
            @(posedge pclk);
            #5;
        end
        rdata = prdata;
        err = pslverr;
        @(posedge pclk);
        #5;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        txn_t             t;
        logic [bus_w-1:0] rdata;
        logic             err;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        build_table();
        table_built = 1'b1;
        repeat (8) @(posedge pclk);
        #5;
        rst = 1'b0;
        if (pready !== 1'b0 || pslverr !== 1'b0) begin
            $display("pready or pslverr was not low after reset");
            errors++;
        end
        foreach (txns[n]) begin
            t = txns[n];
            apb_transfer(t, rdata, err);
            if (err !== t.exp_err) begin
                $display("ERROR pslverr paddr %h: got %h expected %h", t.addr, err, t.exp_err);
                errors++;
            end
            if (t.check_rdata && rdata !== t.exp_rdata) begin
                $display("ERROR prdata paddr %h: got %h expected %h", t.addr, rdata,
                         t.exp_rdata);
                errors++;
            end
        end
        $display("Checks done with %0d errors and %0d assertion failures", errors,
                 dut0.port0.asrt0.fail_count);
        if (errors == 0 && dut0.port0.asrt0.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Every transfer needs at most three cycles, four are allowed
    initial begin
        wait (table_built);
        repeat (txns.size() * 4 + 8 + 20) @(posedge pclk);
        $display("Timeout: the transfers did not complete in the expected time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
logic/ecc_pkg.sv
logic/ecc_codec.sv
logic/ecc_store.sv
logic/ecc_apb_port.sv
logic/ecc_scratchpad.sv
testbench/ecc_scratchpad_assertions.sv
testbench/ecc_scratchpad_tb.sv
